/* common/rvPkg.sv */
`default_nettype none

package rvPkg;

    localparam int xlen = 32;
    localparam int regAddrW = 5;

    typedef logic [xlen-1:0] wordT;
    typedef logic [regAddrW-1:0] regIdxT;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        opIllegal = 7'b0000000,
        opLui     = 7'b0110111,
        opAuipc   = 7'b0010111,
        opOpImm   = 7'b0010011,
        opOp      = 7'b0110011,
        opJal     = 7'b1101111,
        opBranch  = 7'b1100011,
        opLoad    = 7'b0000011,
        opStore   = 7'b0100011
    } opcodeE;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluPassB
    } aluOpE;

    // blt and bge compare signed
    typedef enum logic [2:0] {
        brNone,
        brJal,
        brEq,
        brNe,
        brLt,
        brGe
    } branchE;

    typedef enum logic [2:0] {
        immI,
        immU,
        immS,
        immB,
        immJ
    } immKindE;

    typedef struct packed {
        wordT   pc;
        regIdxT rd;
        regIdxT rs1;
        regIdxT rs2;
        wordT   imm;
        aluOpE  aluOp;
        branchE branch;
        logic   selPcA;
        logic   selImmB;
        logic   selFourB;
        logic   regWr;
        logic   memRd;
        logic   memWr;
        logic   valid;
    } decodedT;

    // OF/EX bundle with forwarded operands
    typedef struct packed {
        decodedT dec;
        wordT    busA;
        wordT    busB;
    } execT;

    typedef struct packed {
        regIdxT rd;
        wordT   data;
        logic   regWr;
    } writebackT;

    typedef struct packed {
        wordT addr;
        wordT wrData;
        logic we;
        logic re;
    } dataReqT;

endpackage

`default_nettype wire

/* operand/regFile.sv */
`timescale 1ns/10ps
`default_nettype none

module regFile (
    input  wire                   WrClk,
    input  wire rvPkg::regIdxT    raddrA,
    input  wire rvPkg::regIdxT    raddrB,
    input  wire rvPkg::writebackT wb,
    output rvPkg::wordT           busA,
    output rvPkg::wordT           busB
);
    import rvPkg::*;

    // No storage for x0
    wordT regs [1:(2**regAddrW)-1];

    always_ff @(posedge WrClk) begin
        if (wb.regWr && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

    assign busA = (raddrA == '0) ? '0 : regs[raddrA];
    assign busB = (raddrB == '0) ? '0 : regs[raddrB];

endmodule

`default_nettype wire

/* fetch/instrDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module instrDecoder (
    input  wire rvPkg::wordT   instr,
    input  wire rvPkg::wordT   pc,
    output rvPkg::decodedT     decoded
);
    import rvPkg::*;

    opcodeE     op;
    immKindE    immKind;
    logic [2:0] funct3;
    logic       altBit;
    logic       useRs1;
    logic       useRs2;

    function automatic aluOpE aluFromFunct(input logic [2:0] f3, input logic alt);
        aluOpE res;
        case (f3)
            3'b000:  res = alt ? aluSub : aluAdd;
            3'b001:  res = aluSll;
            3'b010:  res = aluSlt;
            3'b011:  res = aluSltu;
            3'b100:  res = aluXor;
            3'b101:  res = alt ? aluSra : aluSrl;
            3'b110:  res = aluOr;
            default: res = aluAnd;
        endcase
        return res;
    endfunction

    assign op = opcodeE'(instr[6:0]);
    assign funct3 = instr[14:12];
    // addi has no sub form, so bit 30 only counts for op and right shifts
    assign altBit = instr[30] && ((op == opOp) || (funct3 == 3'b101));

    always_comb begin
        decoded = '0;
        decoded.pc = pc;
        decoded.rd = instr[11:7];
        decoded.valid = 1'b1;
        immKind = immI;
        useRs1 = 1'b0;
        useRs2 = 1'b0;

        case (op)
            opLui: begin
                immKind = immU;
                decoded.selImmB = 1'b1;
                decoded.aluOp = aluPassB;
                decoded.regWr = 1'b1;
            end
            opAuipc: begin
                immKind = immU;
                decoded.selPcA = 1'b1;
                decoded.selImmB = 1'b1;
                decoded.regWr = 1'b1;
            end
            opOpImm: begin
                useRs1 = 1'b1;
                decoded.selImmB = 1'b1;
                decoded.aluOp = aluFromFunct(funct3, altBit);
                decoded.regWr = 1'b1;
            end
            opOp: begin
                useRs1 = 1'b1;
                useRs2 = 1'b1;
                decoded.aluOp = aluFromFunct(funct3, altBit);
                decoded.regWr = 1'b1;
            end
            opJal: begin
                // Link value is pc + 4
                immKind = immJ;
                decoded.selPcA = 1'b1;
                decoded.selFourB = 1'b1;
                decoded.branch = brJal;
                decoded.regWr = 1'b1;
            end
            opBranch: begin
                immKind = immB;
                useRs1 = 1'b1;
                useRs2 = 1'b1;
                case (funct3)
                    3'b000:  decoded.branch = brEq;
                    3'b001:  decoded.branch = brNe;
                    3'b100:  decoded.branch = brLt;
                    3'b101:  decoded.branch = brGe;
                    default: decoded.branch = brNone;
                endcase
            end
            opLoad: begin
                useRs1 = 1'b1;
                decoded.selImmB = 1'b1;
                decoded.memRd = 1'b1;
                decoded.regWr = 1'b1;
            end
            opStore: begin
                immKind = immS;
                useRs1 = 1'b1;
                useRs2 = 1'b1;
                decoded.selImmB = 1'b1;
                decoded.memWr = 1'b1;
            end
            default: begin
            end
        endcase

        // Unused source fields read as x0 so they never match a hazard
        decoded.rs1 = useRs1 ? instr[19:15] : '0;
        decoded.rs2 = useRs2 ? instr[24:20] : '0;

        case (immKind)
            immU:    decoded.imm = {instr[31:12], 12'b0};
            immS:    decoded.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            immB:    decoded.imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            immJ:    decoded.imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default: decoded.imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

endmodule

`default_nettype wire

/* fetch/fetchStage.sv */
`timescale 1ns/10ps
`default_nettype none

module fetchStage #(
    parameter rvPkg::wordT resetPc = 32'h0000_0000
) (
    input  wire                WrClk,
    input  wire                reset,
    input  wire                stall,
    input  wire                redirect,
    input  wire rvPkg::wordT   redirectPc,
    output rvPkg::wordT        imemAddr,
    input  wire rvPkg::wordT   imemData,
    output rvPkg::decodedT     decoded
);
    import rvPkg::*;

    wordT    pc;
    decodedT rawDecoded;
    logic    jalTaken;

    instrDecoder decoder_i (
        .instr(imemData),
        .pc(pc),
        .decoded(rawDecoded)
    );

    // Instruction in IF is dropped when execute redirects
    always_comb begin
        decoded = rawDecoded;
        decoded.valid = rawDecoded.valid && !reset && !redirect;
    end

    assign jalTaken = decoded.valid && (decoded.branch == brJal);
    assign imemAddr = pc;

    always_ff @(posedge WrClk) begin
        if (reset) begin
            pc <= resetPc;
        end else if (redirect) begin
            pc <= redirectPc;
        end else if (!stall) begin
            if (jalTaken) begin
                pc <= pc + rawDecoded.imm;
            end else begin
                pc <= pc + 32'd4;
            end
        end
    end

endmodule

`default_nettype wire

/* operand/operandStage.sv */
`timescale 1ns/10ps
`default_nettype none

module operandStage (
    input  wire                   WrClk,
    input  wire                   reset,
    input  wire rvPkg::decodedT   decoded,
    input  wire                   flush,
    input  wire rvPkg::writebackT exFwd,
    input  wire                   exIsLoad,
    input  wire rvPkg::writebackT wb,
    output logic                  stall,
    output rvPkg::execT           exBundle
);
    import rvPkg::*;

    decodedT ifOf;
    wordT    fileA;
    wordT    fileB;
    wordT    busA;
    wordT    busB;

    // Youngest producer wins, x0 is always zero
    function automatic wordT forwardOperand(
        input regIdxT    idx,
        input wordT      fileVal,
        input writebackT exRes,
        input writebackT memRes
    );
        wordT val;
        if (idx == '0) begin
            val = '0;
        end else if (exRes.regWr && (exRes.rd == idx)) begin
            val = exRes.data;
        end else if (memRes.regWr && (memRes.rd == idx)) begin
            val = memRes.data;
        end else begin
            val = fileVal;
        end
        return val;
    endfunction

    regFile regFile_i (
        .WrClk(WrClk),
        .raddrA(ifOf.rs1),
        .raddrB(ifOf.rs2),
        .wb(wb),
        .busA(fileA),
        .busB(fileB)
    );

    assign busA = forwardOperand(ifOf.rs1, fileA, exFwd, wb);
    assign busB = forwardOperand(ifOf.rs2, fileB, exFwd, wb);

    // Load in EX has no data yet, hold the consumer one cycle
    assign stall = exIsLoad && ifOf.valid &&
                   (((ifOf.rs1 != '0) && (ifOf.rs1 == exFwd.rd)) ||
                    ((ifOf.rs2 != '0) && (ifOf.rs2 == exFwd.rd)));

    // IF/OF
    always_ff @(posedge WrClk) begin
        if (reset || flush) begin
            ifOf.valid <= 1'b0;
        end else if (!stall) begin
            ifOf <= decoded;
        end
    end

    // OF/EX, bubble on stall
    always_ff @(posedge WrClk) begin
        if (reset || flush || stall) begin
            exBundle.dec.valid <= 1'b0;
        end else begin
            exBundle.dec <= ifOf;
            exBundle.busA <= busA;
            exBundle.busB <= busB;
        end
    end

endmodule

`default_nettype wire

/* execute/executeStage.sv */
`timescale 1ns/10ps
`default_nettype none

module executeStage (
    input  wire                 WrClk,
    input  wire                 reset,
    input  wire rvPkg::execT    exBundle,
    input  wire rvPkg::wordT    dmemRdData,
    output logic                redirect,
    output rvPkg::wordT         redirectPc,
    output logic                flush,
    output rvPkg::writebackT    exFwd,
    output logic                exIsLoad,
    output rvPkg::writebackT    wb,
    output rvPkg::dataReqT      dataReq,
    output logic                retired
);
    import rvPkg::*;

    decodedT                   dec;
    wordT                      opA;
    wordT                      opB;
    wordT                      aluRes;
    logic [$clog2(xlen)-1:0]   shamt;
    logic                      eqFlag;
    logic                      ltFlag;
    logic                      taken;

    // EX/M state
    writebackT mWb;
    wordT      mWrData;
    logic      mWe;
    logic      mRe;
    logic      mValid;

    assign dec = exBundle.dec;

    assign opA = dec.selPcA ? dec.pc : exBundle.busA;
    assign opB = dec.selImmB  ? dec.imm :
                 dec.selFourB ? 32'd4 :
                 exBundle.busB;
    assign shamt = opB[$clog2(xlen)-1:0];

    assign eqFlag = (opA == opB);
    assign ltFlag = ($signed(opA) < $signed(opB));

    always_comb begin
        case (dec.aluOp)
            aluSub:   aluRes = opA - opB;
            aluSll:   aluRes = opA << shamt;
            aluSlt:   aluRes = wordT'(ltFlag);
            aluSltu:  aluRes = wordT'(opA < opB);
            aluXor:   aluRes = opA ^ opB;
            aluSrl:   aluRes = opA >> shamt;
            aluSra:   aluRes = wordT'($signed(opA) >>> shamt);
            aluOr:    aluRes = opA | opB;
            aluAnd:   aluRes = opA & opB;
            aluPassB: aluRes = opB;
            default:  aluRes = opA + opB;
        endcase
    end

    // Branches are predicted not taken, so only a taken one redirects
    always_comb begin
        case (dec.branch)
            brEq:    taken = eqFlag;
            brNe:    taken = !eqFlag;
            brLt:    taken = ltFlag;
            brGe:    taken = !ltFlag;
            default: taken = 1'b0;
        endcase
    end

    assign redirect = dec.valid && taken;
    assign redirectPc = dec.pc + dec.imm;
    assign flush = redirect;

    assign exFwd = '{rd: dec.rd, data: aluRes, regWr: dec.valid && dec.regWr};
    assign exIsLoad = dec.valid && dec.memRd;

    always_ff @(posedge WrClk) begin
        mWb.rd <= dec.rd;
        mWb.data <= aluRes;
        mWrData <= exBundle.busB;
        if (reset) begin
            mWb.regWr <= 1'b0;
            mWe <= 1'b0;
            mRe <= 1'b0;
            mValid <= 1'b0;
        end else begin
            mWb.regWr <= dec.valid && dec.regWr;
            mWe <= dec.valid && dec.memWr;
            mRe <= dec.valid && dec.memRd;
            mValid <= dec.valid;
        end
    end

    // Memory stage
    assign dataReq = '{addr: mWb.data, wrData: mWrData, we: mWe, re: mRe};

    always_comb begin
        wb = mWb;
        if (mRe) begin
            wb.data = dmemRdData;
        end
    end

    assign retired = mValid;

endmodule

`default_nettype wire

/* hdl/cpuTop.sv */
`timescale 1ns/10ps
`default_nettype none

module cpuTop #(
    parameter rvPkg::wordT resetPc = 32'h0000_0000
) (
    input  wire                WrClk,
    input  wire                reset,
    output rvPkg::wordT        imemAddr,
    input  wire rvPkg::wordT   imemData,
    output rvPkg::dataReqT     dataReq,
    input  wire rvPkg::wordT   dmemRdData,
    output logic               retired
);
    import rvPkg::*;

    decodedT   decoded;
    execT      exBundle;
    writebackT exFwd;
    writebackT wb;
    wordT      redirectPc;
    logic      stall;
    logic      redirect;
    logic      flush;
    logic      exIsLoad;

    fetchStage #(
        .resetPc(resetPc)
    ) fetch_i (
        .WrClk(WrClk),
        .reset(reset),
        .stall(stall),
        .redirect(redirect),
        .redirectPc(redirectPc),
        .imemAddr(imemAddr),
        .imemData(imemData),
        .decoded(decoded)
    );

    operandStage operand_i (
        .WrClk(WrClk),
        .reset(reset),
        .decoded(decoded),
        .flush(flush),
        .exFwd(exFwd),
        .exIsLoad(exIsLoad),
        .wb(wb),
        .stall(stall),
        .exBundle(exBundle)
    );

    executeStage execute_i (
        .WrClk(WrClk),
        .reset(reset),
        .exBundle(exBundle),
        .dmemRdData(dmemRdData),
        .redirect(redirect),
        .redirectPc(redirectPc),
        .flush(flush),
        .exFwd(exFwd),
        .exIsLoad(exIsLoad),
        .wb(wb),
        .dataReq(dataReq),
        .retired(retired)
    );

endmodule

`default_nettype wire

/* dv/pipeline_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module pipelineChk (
    input wire                 WrClk,
    input wire                 reset,
    input wire                 redirect,
    input wire rvPkg::dataReqT dataReq,
    input wire                 retired
);

    weReExclusive: assert property (@(posedge WrClk) disable iff (reset)
        !(dataReq.we && dataReq.re))
        else $error("Data memory read and write requested together");

    // Registers are cleared by the first reset edge
    quietInReset: assert property (@(posedge WrClk)
        reset |=> (!retired && !dataReq.we && !dataReq.re))
        else $error("Retire or memory request active during reset");

    // Both younger instructions of a taken branch are squashed
    shadowNotRetired: assert property (@(posedge WrClk) disable iff (reset)
        ($past(redirect, 2) || $past(redirect, 3)) |-> !retired)
        else $error("Instruction in a taken branch shadow retired");

endmodule

bind executeStage pipelineChk chk_i (
    .WrClk(WrClk),
    .reset(reset),
    .redirect(redirect),
    .dataReq(dataReq),
    .retired(retired)
);

`default_nettype wire

/* dv/cpuMonitor.sv */
`timescale 1ns/10ps
`default_nettype none

module cpuMonitor #(
    parameter int maxStores = 128
) (
    input  wire                 WrClk,
    input  wire                 reset,
    input  wire rvPkg::dataReqT dataReq,
    input  wire                 retired,
    input  var rvPkg::wordT     expAddr [maxStores],
    input  var rvPkg::wordT     expData [maxStores],
    input  var int              expCount,
    input  var int              expRetired,
    output int                  storeErrors,
    output int                  retireErrors,
    output logic                done
);
    import rvPkg::*;

    int seenStores;
    int retireCount;

    task automatic checkStore();
        if (seenStores >= expCount) begin
            $display("Error at %0t: unexpected store of %h to %h",
                     $time, dataReq.wrData, dataReq.addr);
            storeErrors++;
        end else begin
            if ((dataReq.addr !== expAddr[seenStores]) ||
                (dataReq.wrData !== expData[seenStores])) begin
                $display("Error at %0t: store %0d wrote %h to %h, expected %h to %h",
                         $time, seenStores, dataReq.wrData, dataReq.addr,
                         expData[seenStores], expAddr[seenStores]);
                storeErrors++;
            end
            seenStores++;
            // Last store is the final instruction before the loop
            if (seenStores == expCount) begin
                done = 1'b1;
                if (retireCount != expRetired) begin
                    $display("Error at %0t: %0d instructions retired, expected %0d",
                             $time, retireCount, expRetired);
                    retireErrors++;
                end
            end
        end
    endtask

    always @(posedge WrClk) begin
        if (reset) begin
            seenStores = 0;
            retireCount = 0;
            storeErrors = 0;
            retireErrors = 0;
            done = 1'b0;
        end else begin
            if (retired) begin
                retireCount++;
            end
            if (dataReq.we) begin
                checkStore();
            end
        end
    end

endmodule

`default_nettype wire

/* dv/cpuTb.sv */
`timescale 1ns/10ps
`default_nettype none

module cpuTb;
    import rvPkg::*;

    localparam wordT progBase = 32'h0000_0100;
    localparam int progWords = 256;
    localparam int dmemWords = 512;
    localparam int maxStores = 128;
    localparam int rounds = 16;

    // RV32I major opcodes
    localparam logic [6:0] oLui = 7'b0110111;
    localparam logic [6:0] oAuipc = 7'b0010111;
    localparam logic [6:0] oOpImm = 7'b0010011;
    localparam logic [6:0] oOp = 7'b0110011;
    localparam logic [6:0] oJal = 7'b1101111;
    localparam logic [6:0] oBranch = 7'b1100011;
    localparam logic [6:0] oLoad = 7'b0000011;
    localparam logic [6:0] oStore = 7'b0100011;

    logic        WrClk;
    logic        reset;
    wordT        imemAddr;
    wordT        imemData;
    dataReqT     dataReq;
    wordT        dmemRdData;
    logic        retired;

    wordT        prog [progWords];
    wordT        dmem [dmemWords];
    wordT        expAddr [maxStores];
    wordT        expData [maxStores];
    int          progLen;
    int          imemIdx;
    int          storeAddr;
    int          expCount;
    int          expRetired;
    int          cycles;
    int          cycleLimit;
    int          otherErrors;
    int          storeErrors;
    int          retireErrors;
    logic        done;
    logic [31:0] lfsr;

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [4:0] randReg();
        return 5'(1 + (randBits(3) % 7));
    endfunction

    function automatic wordT fillWord(input int idx);
        wordT a;
        a = wordT'(idx);
        return (a * 32'h9e37_79b9) ^ {a[15:0], ~a[15:0]};
    endfunction

    function automatic wordT encR(input logic [6:0] f7, input logic [4:0] rs2,
                                  input logic [4:0] rs1, input logic [2:0] f3,
                                  input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, oOp};
    endfunction

    function automatic wordT encI(input logic [11:0] imm, input logic [4:0] rs1,
                                  input logic [2:0] f3, input logic [4:0] rd,
                                  input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic wordT encS(input logic [11:0] imm, input logic [4:0] rs2,
                                  input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], oStore};
    endfunction

    function automatic wordT encB(input logic [12:0] imm, input logic [4:0] rs2,
                                  input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], oBranch};
    endfunction

    function automatic wordT encU(input logic [19:0] imm, input logic [4:0] rd,
                                  input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic wordT encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, oJal};
    endfunction

    task automatic emit(input wordT w);
        prog[progLen] = w;
        progLen++;
    endtask

    // Every store goes to a fresh address
    task automatic storeReg(input logic [4:0] r);
        emit(encS(12'(storeAddr), r, 5'd0));
        storeAddr += 4;
    endtask

    task automatic emitAlu(input logic [4:0] rd, input logic [4:0] rs1,
                           input logic [4:0] rs2, input logic useImm);
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        f3 = 3'(randBits(3));
        alt = 1'(randBits(1));
        imm = 12'(randBits(12));
        if (useImm) begin
            if (f3 == 3'b001) begin
                imm = {7'b0, imm[4:0]};
            end else if (f3 == 3'b101) begin
                imm = {1'b0, alt, 5'b0, imm[4:0]};
            end
            emit(encI(imm, rs1, f3, rd, oOpImm));
        end else begin
            alt = alt && ((f3 == 3'b000) || (f3 == 3'b101));
            emit(encR({1'b0, alt, 5'b0}, rs2, rs1, f3, rd));
        end
    endtask

    task automatic buildProgram();
        logic [4:0] a;
        logic [4:0] b;
        logic [4:0] c;
        logic [4:0] other;
        logic [2:0] brF3;
        int         kind;
        progLen = 0;
        storeAddr = 'h400;
        for (int r = 1; r < 8; r++) begin
            emit(encU(20'(randBits(20)), 5'(r), oLui));
            emit(encI(12'(randBits(12)), 5'(r), 3'b000, 5'(r), oOpImm));
        end
        for (int n = 0; n < rounds; n++) begin
            a = randReg();
            b = 5'((a % 7) + 1);
            c = 5'((b % 7) + 1);
            kind = int'(randBits(3) % 6);
            case (kind)
                0: begin
                    // Chain reads from EX and from M
                    emitAlu(a, randReg(), randReg(), 1'(randBits(1)));
                    emitAlu(b, a, randReg(), 1'(randBits(1)));
                    emitAlu(c, a, b, 1'b0);
                    storeReg(a);
                    storeReg(b);
                    storeReg(c);
                end
                1: begin
                    emit(encU(20'(randBits(20)), a, oLui));
                    emit(encU(20'(randBits(20)), b, oAuipc));
                    emitAlu(c, a, b, 1'b0);
                    storeReg(a);
                    storeReg(b);
                    storeReg(c);
                end
                2: begin
                    emit(encI({2'b00, 8'(randBits(8)), 2'b00}, 5'd0, 3'b010, a, oLoad));
                    emitAlu(c, a, b, 1'b0);
                    storeReg(c);
                    storeReg(a);
                end
                3: begin
                    // Two shadow instructions, then the target
                    brF3 = {1'(randBits(1)), 1'b0, 1'(randBits(1))};
                    other = (randBits(1) != 0) ? a : b;
                    emit(encB(13'd12, other, a, brF3));
                    emit(encI(12'(randBits(12)), a, 3'b000, a, oOpImm));
                    storeReg(a);
                    storeReg(a);
                end
                4: begin
                    emit(encJ(21'd12, a));
                    emit(encI(12'(randBits(12)), b, 3'b000, b, oOpImm));
                    storeReg(b);
                    storeReg(a);
                    storeReg(b);
                end
                default: begin
                    emitAlu(a, b, 5'd0, 1'b1);
                    emitAlu(a, a, 5'd0, 1'b1);
                    storeReg(a);
                end
            endcase
        end
        storeReg(5'd1);
        emit(encJ(21'd0, 5'd0));
    endtask

    function automatic wordT aluRef(input logic [2:0] f3, input logic alt,
                                    input wordT a, input wordT b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? wordT'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // ISA interpreter that runs until the jump to itself
    function automatic int refRun();
        wordT       regs [32];
        wordT       mem [dmemWords];
        wordT       pc;
        wordT       instr;
        wordT       a;
        wordT       b;
        wordT       res;
        wordT       addr;
        wordT       iImm;
        wordT       sImm;
        wordT       bImm;
        wordT       jImm;
        logic [6:0] opc;
        logic [2:0] f3;
        logic       taken;
        logic       wr;
        int         count;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < dmemWords; i++) begin
            mem[i] = fillWord(i);
        end
        pc = progBase;
        count = 0;
        expCount = 0;
        while (count < 8 * progWords) begin
            instr = prog[int'((pc - progBase) >> 2)];
            opc = instr[6:0];
            f3 = instr[14:12];
            a = regs[instr[19:15]];
            b = regs[instr[24:20]];
            iImm = {{20{instr[31]}}, instr[31:20]};
            sImm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            bImm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            jImm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            if ((opc == oJal) && (jImm == '0)) begin
                break;
            end
            count++;
            res = '0;
            wr = 1'b1;
            taken = 1'b0;
            case (opc)
                oLui:   res = {instr[31:12], 12'b0};
                oAuipc: res = pc + {instr[31:12], 12'b0};
                oOpImm: res = aluRef(f3, instr[30] && (f3 == 3'b101), a, iImm);
                oOp:    res = aluRef(f3, instr[30], a, b);
                oJal:   res = pc + 32'd4;
                oLoad: begin
                    addr = a + iImm;
                    res = mem[addr[10:2]];
                end
                oStore: begin
                    wr = 1'b0;
                    addr = a + sImm;
                    mem[addr[10:2]] = b;
                    expAddr[expCount] = addr;
                    expData[expCount] = b;
                    expCount++;
                end
                oBranch: begin
                    wr = 1'b0;
                    case (f3)
                        3'b000:  taken = (a == b);
                        3'b001:  taken = (a != b);
                        3'b100:  taken = ($signed(a) < $signed(b));
                        default: taken = ($signed(a) >= $signed(b));
                    endcase
                end
                default: wr = 1'b0;
            endcase
            if (wr && (instr[11:7] != 5'd0)) begin
                regs[instr[11:7]] = res;
            end
            if (opc == oJal) begin
                pc = pc + jImm;
            end else if (taken) begin
                pc = pc + bImm;
            end else begin
                pc = pc + 32'd4;
            end
        end
        return count;
    endfunction

    // Both memories answer in the same cycle
    always_comb begin
        imemIdx = int'((imemAddr - progBase) >> 2);
        if (imemIdx < progLen) begin
            imemData = prog[imemIdx];
        end else begin
            imemData = 32'h0000_0013;
        end
    end

    // Data only comes back for a read request
    assign dmemRdData = dataReq.re ? dmem[dataReq.addr[10:2]] : '0;

    always @(posedge WrClk) begin
        if (reset) begin
            for (int i = 0; i < dmemWords; i++) begin
                dmem[i] <= fillWord(i);
            end
        end else if (dataReq.we) begin
            dmem[dataReq.addr[10:2]] <= dataReq.wrData;
        end
    end

    cpuTop #(
        .resetPc(progBase)
    ) dut_i (
        .WrClk(WrClk),
        .reset(reset),
        .imemAddr(imemAddr),
        .imemData(imemData),
        .dataReq(dataReq),
        .dmemRdData(dmemRdData),
        .retired(retired)
    );

    cpuMonitor #(
        .maxStores(maxStores)
    ) mon_i (
        .WrClk(WrClk),
        .reset(reset),
        .dataReq(dataReq),
        .retired(retired),
        .expAddr(expAddr),
        .expData(expData),
        .expCount(expCount),
        .expRetired(expRetired),
        .storeErrors(storeErrors),
        .retireErrors(retireErrors),
        .done(done)
    );

    initial begin
        WrClk = 1'b0;
        forever begin
            #5 WrClk = ~WrClk;
        end
    end

    initial begin
        reset = 1'b1;
        lfsr = 32'hea5e;
        otherErrors = 0;
        buildProgram();
        expRetired = refRun();
        cycleLimit = 40 + 4 * progLen;
        repeat (5) @(negedge WrClk);
        reset = 1'b0;
        cycles = 0;
        while (!done && (cycles < cycleLimit)) begin
            @(negedge WrClk);
            cycles++;
        end
        if (!done) begin
            $display("Timeout: only part of the stores seen after %0d cycles", cycles);
            otherErrors++;
        end else begin
            // Stray stores from the final loop would show here
            repeat (8) @(negedge WrClk);
        end
        $display("Closing: %0d store errors, %0d retire errors, %0d other errors",
                 storeErrors, retireErrors, otherErrors);
        if ((storeErrors + retireErrors + otherErrors) == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
common/rvPkg.sv
operand/regFile.sv
fetch/instrDecoder.sv
fetch/fetchStage.sv
operand/operandStage.sv
execute/executeStage.sv
hdl/cpuTop.sv
dv/pipeline_chk.sv
dv/cpuMonitor.sv
dv/cpuTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the CPU testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/10ps --top-module cpuTb \
    -f compile.f -o cpuSim \
    && ./obj_dir/cpuSim > sim.log 2>&1 \
    && cat sim.log \
    && ! grep -q "Something failed" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
